//--- flist.f
+incdir+include
src/icachePkg.sv
src/cacheWay.sv
src/icacheFsm.sv
src/icache.sv
src/pcStage.sv
src/fetchSubsystem.sv
tb/fetchBusResponder.sv
tb/fetchSubsystemTb.sv

//--- run.sh
#!/bin/sh
# build the fetch subsystem testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module fetchSubsystemTb -f flist.f -o fetchSim \
  > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/fetchSim > sim.log 2>&1
grep -q "Verification failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Verification passed" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"

//--- tb/fetchSubsystemTb.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module fetchSubsystemTb;

  // enough for a spill that misses twice with hold cycles mixed in
  localparam int waitLimit = 400;

  logic                    clk;
  logic                    reset;
  logic                    hold;
  logic                    redirect;
  logic [`PA_BITS-1:0]     redirectPc;
  icachePkg::fetchBusReq_t busReq;
  icachePkg::fetchBusRsp_t busRsp;
  icachePkg::fetchOut_t    instrOut;
  int                      readCount;

  logic [31:0]          rngState;
  icachePkg::fetchOut_t lastRun[$];

  fetchSubsystem u_fetchSubsystem (
    .clk       (clk),
    .reset     (reset),
    .hold      (hold),
    .redirect  (redirect),
    .redirectPc(redirectPc),
    .busReq    (busReq),
    .busRsp    (busRsp),
    .instrOut  (instrOut)
  );

  fetchBusResponder u_fetchBusResponder (
    .clk      (clk),
    .busReq   (busReq),
    .busRsp   (busRsp),
    .readCount(readCount)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // expected content
  ////////////////////

  // same address hash that the responder serves
  function automatic logic [15:0] halfAt(input logic [31:0] adr);
    logic [31:0] h;
    h = adr * 32'h9e3779b1;
    h = h ^ (h >> 16);
    return {h[15:2], h[9] ? 2'b11 : {h[4], 1'b0}};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // a halfword whose low bits are not 11 starts a compressed instruction
  function automatic logic [`PA_BITS-1:0] instrSize(input logic [`PA_BITS-1:0] pc);
    logic [15:0] low;
    low = halfAt(pc);
    return (low[1:0] != 2'b11) ? 2 : 4;
  endfunction

  // the raw 32 bits at pc are presented even for a compressed instruction
  function automatic icachePkg::fetchOut_t expectedAt(input logic [`PA_BITS-1:0] pc);
    icachePkg::fetchOut_t exp;
    logic [15:0]          low;
    low            = halfAt(pc);
    exp.valid      = 1'b1;
    exp.pc         = pc;
    exp.instr      = {halfAt(pc + 2), low};
    exp.compressed = (low[1:0] != 2'b11);
    return exp;
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic reportMismatch(input string msg);
    abortRun($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
  endtask

  task automatic compareFetchOut(input icachePkg::fetchOut_t got,
                                 input icachePkg::fetchOut_t exp, input string what);
    bit same;
    // an invalid output carries no instruction so only valid and pc are defined
    if (exp.valid) begin
      same = (got == exp);
    end else begin
      same = (!got.valid && got.pc == exp.pc);
    end
    if (!same) begin
      reportMismatch($sformatf(
        "%s: got v%0b pc %h instr %h c%0b, expected v%0b pc %h instr %h c%0b",
        what, got.valid, got.pc, got.instr, got.compressed,
        exp.valid, exp.pc, exp.instr, exp.compressed));
    end
  endtask

  task automatic compareCount(input int got, input int exp, input string what);
    if (got != exp) begin
      reportMismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic compareBusReq(input icachePkg::fetchBusReq_t got,
                               input icachePkg::fetchBusReq_t exp, input string what);
    if (got != exp) begin
      reportMismatch($sformatf("%s: got read %0b adr %h, expected read %0b adr %h",
        what, got.read, got.adr, exp.read, exp.adr));
    end
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////

  // inputs change 1 ns after the edge and outputs are read at the same point
  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  // the instruction on display is accepted together with the redirect
  task automatic redirectTo(input logic [`PA_BITS-1:0] target);
    int waited;
    waited = 0;
    while (!instrOut.valid) begin
      if (waited == waitLimit) begin
        abortRun("timed out waiting for an instruction to redirect from");
      end
      nextCycle();
      waited++;
    end
    hold       = 1'b0;
    redirect   = 1'b1;
    redirectPc = target;
    nextCycle();
    redirect = 1'b0;
  endtask

  // redirects to start and follows the content rule until the next instruction
  // would sit in the last halfword before endPc
  // the final instruction is checked and then left on display under hold, so no
  // line past endPc is ever requested
  task automatic walkLines(input logic [`PA_BITS-1:0] start, input logic [`PA_BITS-1:0] endPc,
                           input bit holdRandomly, input int expReads, input string what);
    logic [`PA_BITS-1:0] pc;
    int                  readsBefore;
    int                  waited;
    bit                  done;
    redirectTo(start);
    readsBefore = readCount;
    lastRun.delete();
    pc   = start;
    done = 1'b0;
    while (!done) begin
      waited = 0;
      hold   = holdRandomly && (nextRandom() % 3 == 0);
      while (!instrOut.valid || hold) begin
        // a held instruction has to stay exactly as it was
        if (instrOut.valid) begin
          compareFetchOut(instrOut, expectedAt(pc), {what, " under hold"});
        end
        if (waited == waitLimit) begin
          abortRun($sformatf("timed out in %s waiting for the instruction at %h", what, pc));
        end
        nextCycle();
        waited++;
        hold = holdRandomly && (nextRandom() % 3 == 0);
      end
      compareFetchOut(instrOut, expectedAt(pc), what);
      lastRun.push_back(instrOut);
      pc = pc + instrSize(pc);
      if (pc >= endPc - 2) begin
        hold = 1'b1;
        done = 1'b1;
      end else begin
        nextCycle();
      end
    end
    compareCount(readCount - readsBefore, expReads, {what, " bus reads"});
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  // outputs are checked while reset is still high and then the first line at pc 0 is fetched
  task automatic checkResetState();
    icachePkg::fetchBusReq_t idleReq;
    icachePkg::fetchOut_t    idleOut;
    int                      waited;
    idleReq = '0;
    idleOut = '0;
    compareBusReq(busReq, idleReq, "bus request in reset");
    compareFetchOut(instrOut, idleOut, "output in reset");
    reset  = 1'b0;
    waited = 0;
    while (!instrOut.valid) begin
      if (waited == waitLimit) begin
        abortRun("timed out waiting for the first instruction after reset");
      end
      nextCycle();
      waited++;
    end
    compareFetchOut(instrOut, expectedAt('0), "first instruction after reset");
    compareCount(readCount, 8, "reads for the line at pc 0");
  endtask

  // three cold lines cost 8 reads each
  task automatic coldFetch();
    walkLines(32'h200, 32'h260, 1'b0, 24, "cold fetch");
  endtask

  // the same lines come back from the cache without a single bus read
  task automatic replayFetch();
    walkLines(32'h200, 32'h260, 1'b0, 0, "replay");
  endtask

  // odd halfword start gives another parse of the same cached lines
  task automatic mixedSizes();
    int numCompressed;
    int numFull;
    numCompressed = 0;
    numFull       = 0;
    walkLines(32'h202, 32'h240, 1'b0, 0, "mixed sizes");
    foreach (lastRun[i]) begin
      if (lastRun[i].compressed) begin
        numCompressed++;
      end else begin
        numFull++;
      end
    end
    if (numCompressed == 0 || numFull == 0) begin
      reportMismatch($sformatf("expected both sizes, saw %0d compressed and %0d full",
        numCompressed, numFull));
    end
  endtask

  // an instruction in halfword 15 of a line is fetched first with the next line
  // cached and then with the next line missing
  task automatic spillMerge();
    walkLines(32'h21e, 32'h240, 1'b0, 0, "spill into a cached line");
    walkLines(32'h25e, 32'h280, 1'b0, 8, "spill into a missing line");
  endtask

  // every accepted instruction has to show up once and in order
  task automatic holdStress();
    walkLines(32'h300, 32'h360, 1'b1, 24, "random hold");
  endtask

  // 1 KiB apart means the same index, so the second line evicts the first
  task automatic aliasRefetch();
    walkLines(32'h600, 32'h620, 1'b0, 8, "aliasing line");
    walkLines(32'h200, 32'h220, 1'b0, 8, "refetch after eviction");
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    reset      = 1'b1;
    hold       = 1'b1;
    redirect   = 1'b0;
    redirectPc = '0;
    rngState   = 32'hbf147434;
    repeat (10) nextCycle();
    checkResetState();
    coldFetch();
    replayFetch();
    mixedSizes();
    spillMerge();
    holdStress();
    aliasRefetch();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- tb/fetchBusResponder.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module fetchBusResponder (
  input  logic                    clk,
  input  icachePkg::fetchBusReq_t busReq,
  output icachePkg::fetchBusRsp_t busRsp,
  output int                      readCount
);

  logic [31:0] rngState;
  int          waitLeft;
  bit          pending;

  ////////////////////
  // memory content
  ////////////////////

  // every halfword is a hash of its full byte address
  // the low two bits come out as 11 for roughly half of them, which marks a full-size instruction
  function automatic logic [15:0] halfAt(input logic [31:0] adr);
    logic [31:0] h;
    h = adr * 32'h9e3779b1;
    h = h ^ (h >> 16);
    return {h[15:2], h[9] ? 2'b11 : {h[4], 1'b0}};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////
  // bus responder
  ////////////////////

  // the request is looked at 1 ns after the edge, when it is settled
  // ack goes out in the same slot, so it lasts exactly one cycle
  initial begin
    busRsp    = '0;
    readCount = 0;
    rngState  = 32'hbf147434;
    waitLeft  = 0;
    pending   = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      busRsp.ack = 1'b0;
      // a new read gets a latency of 0 to 3 cycles
      if (!pending && busReq.read) begin
        rngState = xorshift32(rngState);
        waitLeft = int'(rngState % 4);
        pending  = 1'b1;
      end
      if (pending) begin
        if (waitLeft == 0) begin
          // the address is held by the cache until this ack
          busRsp.data = {halfAt(busReq.adr + 2), halfAt(busReq.adr)};
          busRsp.ack  = 1'b1;
          pending     = 1'b0;
          readCount++;
        end else begin
          waitLeft--;
        end
      end
    end
  end

endmodule

//--- src/fetchSubsystem.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module fetchSubsystem (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   hold,
  input  logic                   redirect,
  input  logic [`PA_BITS-1:0]    redirectPc,
  output icachePkg::fetchBusReq_t busReq,
  input  icachePkg::fetchBusRsp_t busRsp,
  output icachePkg::fetchOut_t    instrOut
);

  logic [`PA_BITS-1:0] pcNext, pcCurrent;
  logic [31:0]         instr;
  logic                compressed, cacheStall, fetchStall;

  // the PC only moves when the cache has an instruction and decode takes it
  assign fetchStall = hold | cacheStall;

  pcStage u_pcStage (
    .clk       (clk),
    .reset     (reset),
    .stall     (fetchStall),
    .compressed(compressed),
    .redirect  (redirect),
    .redirectPc(redirectPc),
    .pcNext    (pcNext),
    .pcCurrent (pcCurrent)
  );

  // the cache only sees hold, a miss runs on regardless
  icache u_icache (
    .clk       (clk),
    .reset     (reset),
    .stall     (hold),
    .pcNext    (pcNext),
    .pcCurrent (pcCurrent),
    .busReq    (busReq),
    .busRsp    (busRsp),
    .instr     (instr),
    .compressed(compressed),
    .cacheStall(cacheStall)
  );

  assign instrOut = '{
    valid:      !cacheStall,
    pc:         pcCurrent,
    instr:      instr,
    compressed: compressed
  };

endmodule

//--- src/pcStage.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module pcStage (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall,
  input  logic                compressed,
  input  logic                redirect,
  input  logic [`PA_BITS-1:0] redirectPc,
  output logic [`PA_BITS-1:0] pcNext,
  output logic [`PA_BITS-1:0] pcCurrent
);

  localparam logic [`PA_BITS-1:0] halfStep = 2;
  localparam logic [`PA_BITS-1:0] wordStep = 4;

  logic [`PA_BITS-1:0] instrSize;
  logic [`PA_BITS-1:0] pcSeq;

  ////////////////////
  // next PC
  ////////////////////

  // compressed instructions are one halfword long, all others two
  assign instrSize = compressed ? halfStep : wordStep;
  assign pcSeq     = pcCurrent + instrSize;

  // pcNext also feeds the cache index, and the cache only uses it
  // in a cycle that accepts an instruction, which is when redirect counts
  assign pcNext = redirect ? redirectPc : pcSeq;

  ////////////////////
  // current PC
  ////////////////////

  // stall covers both a downstream hold and a cache miss or spill
  always_ff @(posedge clk) begin
    if (reset) begin
      pcCurrent <= '0;
    end else if (!stall) begin
      pcCurrent <= pcNext;
    end
  end

endmodule

//--- src/icache.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall,
  input  logic [`PA_BITS-1:0]    pcNext,
  input  logic [`PA_BITS-1:0]    pcCurrent,
  output icachePkg::fetchBusReq_t busReq,
  input  icachePkg::fetchBusRsp_t busRsp,
  output logic [31:0]            instr,
  output logic                   compressed,
  output logic                   cacheStall
);

  localparam int numLines     = `ICACHE_WAYSIZE * 8 / `ICACHE_BLOCKLEN;
  localparam int offsetLen    = $clog2(`ICACHE_BLOCKLEN / 8);
  localparam int indexLen     = $clog2(numLines);
  localparam int tagLen       = `PA_BITS - indexLen - offsetLen;
  localparam int wordsPerLine = `ICACHE_BLOCKLEN / `XLEN;
  localparam int countLen     = $clog2(wordsPerLine);
  localparam int wordOffLen   = $clog2(`XLEN / 8);

  localparam logic [`PA_BITS-1:0] halfStep = 2;

  icachePkg::selAdr_t selAdr, selAdrQ;

  logic [`PA_BITS-1:0]         pcSpill, pcTag;
  logic [indexLen-1:0]         readIndex;
  logic [`ICACHE_BLOCKLEN-1:0] readLine, fillLine;
  logic [`ICACHE_BLOCKLEN+15:0] extLine;
  logic [31:0]                 readData;
  logic [15:0]                 spillHalf;
  logic [countLen-1:0]         fillCount;
  logic hit, spill, spillSave, onSpillLine, readEnable;
  logic busRead, countEnable, countReset, memWrite, fillDone;

  ////////////////////
  // index select
  ////////////////////

  // a spill starts at the last halfword, so two more bytes is the next line base
  assign pcSpill = pcCurrent + halfStep;

  always_comb begin
    case (selAdr)
      icachePkg::nextPc:  readIndex = pcNext[offsetLen +: indexLen];
      icachePkg::spillPc: readIndex = pcSpill[offsetLen +: indexLen];
      default:            readIndex = pcCurrent[offsetLen +: indexLen];
    endcase
  end

  // the tag compare happens a cycle after the index, so the choice is delayed
  // to match and frozen while a fill is running
  always_ff @(posedge clk) begin
    if (reset) begin
      selAdrQ <= icachePkg::currentPc;
    end else if (readEnable) begin
      selAdrQ <= selAdr;
    end
  end

  assign onSpillLine = (selAdrQ == icachePkg::spillPc);
  assign pcTag       = onSpillLine ? pcSpill : pcCurrent;

  cacheWay #(
    .numLines (numLines),
    .indexLen (indexLen),
    .offsetLen(offsetLen),
    .tagLen   (tagLen)
  ) u_cacheWay (
    .clk        (clk),
    .reset      (reset),
    .readIndex  (readIndex),
    .tagAddr    (pcTag),
    .writeEnable(memWrite),
    .writeLine  (fillLine),
    .readLine   (readLine),
    .hit        (hit)
  );

  ////////////////////
  // instruction extract
  ////////////////////

  // zero above the line so halfword 15 only has its own 16 bits
  assign extLine  = {16'b0, readLine};
  assign readData = extLine[pcTag[offsetLen-1:1] * 16 +: 32];
  assign spill    = (pcCurrent[offsetLen-1:1] == '1);

  // low half of a spill, kept while the next line is looked up or filled
  always_ff @(posedge clk) begin
    if (spillSave) begin
      spillHalf <= readData[15:0];
    end
  end

  assign instr      = onSpillLine ? {readData[15:0], spillHalf} : readData;
  assign compressed = (instr[1:0] != 2'b11);

  ////////////////////
  // line fill
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset || countReset) begin
      fillCount <= '0;
    end else if (countEnable) begin
      fillCount <= fillCount + 1'b1;
    end
  end

  assign fillDone = (fillCount == countLen'(wordsPerLine - 1));

  // each acked word goes to the slot picked by the count
  always_ff @(posedge clk) begin
    if (countEnable) begin
      fillLine[fillCount * `XLEN +: `XLEN] <= busRsp.data;
    end
  end

  // line base of the missing line plus the word count
  assign busReq = '{
    read: busRead,
    adr:  {pcTag[`PA_BITS-1:offsetLen], fillCount, {wordOffLen{1'b0}}}
  };

  icacheFsm u_icacheFsm (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .hit        (hit),
    .spill      (spill),
    .ack        (busRsp.ack),
    .fillDone   (fillDone),
    .cacheStall (cacheStall),
    .busRead    (busRead),
    .countEnable(countEnable),
    .countReset (countReset),
    .memWrite   (memWrite),
    .spillSave  (spillSave),
    .selAdr     (selAdr),
    .readEnable (readEnable)
  );

  // a pending read keeps its address until the responder acks it
  assert property (@(posedge clk) disable iff (reset)
    busReq.read && !busRsp.ack |=> busReq.read && $stable(busReq.adr));

endmodule

//--- src/icacheFsm.sv
`timescale 1ns/1ns

module icacheFsm (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  input  logic              hit,
  input  logic              spill,
  input  logic              ack,
  input  logic              fillDone,
  output logic              cacheStall,
  output logic              busRead,
  output logic              countEnable,
  output logic              countReset,
  output logic              memWrite,
  output logic              spillSave,
  output icachePkg::selAdr_t selAdr,
  output logic              readEnable
);

  icachePkg::icacheState_t state, stateNext;

  // set while ready is looking at the second line of a spill,
  // so the spill is not started again under hold
  logic spillLineQ, spillLineNext;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= icachePkg::ready;
      spillLineQ <= 1'b0;
    end else begin
      state      <= stateNext;
      spillLineQ <= spillLineNext;
    end
  end

  ////////////////////
  // next state and outputs
  ////////////////////

  always_comb begin
    stateNext     = state;
    spillLineNext = spillLineQ;
    cacheStall    = 1'b1;
    busRead       = 1'b0;
    countEnable   = 1'b0;
    countReset    = 1'b0;
    memWrite      = 1'b0;
    spillSave     = 1'b0;
    selAdr        = icachePkg::currentPc;
    readEnable    = 1'b1;
    case (state)
      icachePkg::ready: begin
        if (!hit) begin
          // keep the index of the line that missed so it can be refilled
          selAdr    = spillLineQ ? icachePkg::spillPc : icachePkg::currentPc;
          stateNext = spillLineQ ? icachePkg::spillMissFetch : icachePkg::missFetch;
        end else if (spill && !spillLineQ) begin
          stateNext = icachePkg::spillSave;
        end else begin
          cacheStall = 1'b0;
          if (!stall) begin
            selAdr        = icachePkg::nextPc;
            spillLineNext = 1'b0;
          end else if (spillLineQ) begin
            selAdr = icachePkg::spillPc;
          end
        end
      end
      // line fill, one word per ack, index and tag held steady
      icachePkg::missFetch: begin
        busRead     = 1'b1;
        countEnable = ack;
        readEnable  = 1'b0;
        if (ack && fillDone) begin
          stateNext = icachePkg::missWrite;
        end
      end
      icachePkg::missWrite: begin
        memWrite   = 1'b1;
        countReset = 1'b1;
        readEnable = 1'b0;
        stateNext  = icachePkg::missRead;
      end
      icachePkg::missRead: begin
        stateNext = icachePkg::ready;
      end
      // low half is taken from the first line, then the next line is read
      icachePkg::spillSave: begin
        spillSave = 1'b1;
        selAdr    = icachePkg::spillPc;
        stateNext = icachePkg::spillRead;
      end
      icachePkg::spillRead: begin
        selAdr = icachePkg::spillPc;
        if (hit) begin
          spillLineNext = 1'b1;
          stateNext     = icachePkg::ready;
        end else begin
          stateNext = icachePkg::spillMissFetch;
        end
      end
      icachePkg::spillMissFetch: begin
        busRead     = 1'b1;
        countEnable = ack;
        readEnable  = 1'b0;
        selAdr      = icachePkg::spillPc;
        if (ack && fillDone) begin
          stateNext = icachePkg::spillMissWrite;
        end
      end
      icachePkg::spillMissWrite: begin
        memWrite   = 1'b1;
        countReset = 1'b1;
        readEnable = 1'b0;
        selAdr     = icachePkg::spillPc;
        stateNext  = icachePkg::spillMissRead;
      end
      icachePkg::spillMissRead: begin
        selAdr    = icachePkg::spillPc;
        stateNext = icachePkg::spillRead;
      end
      default: begin
        stateNext = icachePkg::ready;
      end
    endcase
  end

  // the way is never written while a fill is still on the bus
  assert property (@(posedge clk) disable iff (reset) !(busRead && memWrite));

  // only ready may present an instruction
  assert property (@(posedge clk) disable iff (reset)
    state != icachePkg::ready |-> cacheStall);

endmodule

//--- src/cacheWay.sv
`timescale 1ns/1ns
`include "icache_cfg.svh"

module cacheWay #(
  parameter int numLines  = `ICACHE_WAYSIZE * 8 / `ICACHE_BLOCKLEN,
  parameter int indexLen  = $clog2(numLines),
  parameter int offsetLen = $clog2(`ICACHE_BLOCKLEN / 8),
  parameter int tagLen    = `PA_BITS - indexLen - offsetLen
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [indexLen-1:0]         readIndex,
  input  logic [`PA_BITS-1:0]         tagAddr,
  input  logic                        writeEnable,
  input  logic [`ICACHE_BLOCKLEN-1:0] writeLine,
  output logic [`ICACHE_BLOCKLEN-1:0] readLine,
  output logic                        hit
);

  ////////////////////
  // storage
  ////////////////////

  logic [`ICACHE_BLOCKLEN-1:0] lineMem [numLines];
  logic [tagLen-1:0]           tagMem  [numLines];
  logic [numLines-1:0]         validBits;

  // everything read for one index lands together one cycle later
  logic [indexLen-1:0] indexQ;
  logic [tagLen-1:0]   storedTag;
  logic                storedValid;

  // the registered index also points at the line that a fill replaces,
  // so the tag that missed is the one overwritten
  always_ff @(posedge clk) begin
    if (reset) begin
      indexQ      <= '0;
      storedValid <= 1'b0;
    end else begin
      indexQ      <= readIndex;
      storedValid <= validBits[readIndex];
    end
  end

  // valid bits only ever get set here, there is no invalidate path
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
    end else if (writeEnable) begin
      validBits[indexQ] <= 1'b1;
    end
  end

  // a read in the same cycle as a write returns the old line
  // and the controller spends one extra cycle to reread it
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      lineMem[indexQ] <= writeLine;
      tagMem[indexQ]  <= tagAddr[`PA_BITS-1 -: tagLen];
    end
    readLine  <= lineMem[readIndex];
    storedTag <= tagMem[readIndex];
  end

  ////////////////////
  // tag compare
  ////////////////////

  assign hit = storedValid && (storedTag == tagAddr[`PA_BITS-1 -: tagLen]);

  // the valid flag sampled with the read must agree with the array
  // at the index that was registered
  assert property (@(posedge clk) disable iff (reset) hit |-> validBits[indexQ]);

endmodule

//--- src/icachePkg.sv
`include "icache_cfg.svh"

package icachePkg;

  ////////////////////
  // fetch bus
  ////////////////////

  // read is held together with a word-aligned address until ack
  typedef struct packed {
    logic                read;
    logic [`PA_BITS-1:0] adr;
  } fetchBusReq_t;

  // ack lasts exactly one cycle and carries one word of the line
  typedef struct packed {
    logic             ack;
    logic [`XLEN-1:0] data;
  } fetchBusRsp_t;

  // instruction handed to decode, raw bits without decompression
  typedef struct packed {
    logic                valid;
    logic [`PA_BITS-1:0] pc;
    logic [31:0]         instr;
    logic                compressed;
  } fetchOut_t;

  ////////////////////
  // controller encodings
  ////////////////////

  typedef enum logic [3:0] {
    ready,
    missFetch,
    missWrite,
    missRead,
    spillSave,
    spillRead,
    spillMissFetch,
    spillMissWrite,
    spillMissRead
  } icacheState_t;

  // source of the index that is sent to the cache way
  typedef enum logic [1:0] {
    nextPc,
    currentPc,
    spillPc
  } selAdr_t;

endpackage

//--- include/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

////////////////////
// fetch bus and address widths
////////////////////

// width of one fetch bus beat, which is also one cache word
`define XLEN 32

// physical address width seen by the PC stage and the fetch bus
`define PA_BITS 32

////////////////////
// instruction cache geometry
////////////////////

// one line is 8 bus words or 16 halfwords
`define ICACHE_BLOCKLEN 256

// a single direct-mapped way of 1 KiB holds 32 lines
`define ICACHE_WAYSIZE 1024

`endif
